//--- build.f
common/vita_tx_pkt_pkg.sv
common/vita_tx_cfg_pkg.sv
logic/tx_settings.sv
vita_tx/vita_tx_deframer.sv
vita_tx/vita_tx_control.sv
logic/dsp_tx_scale.sv
logic/err_pkt_gen.sv
vita_tx/vita_tx_chain.sv
tests/tx_checker.sv
tests/tb_vita_tx_chain.sv

//--- common/vita_tx_cfg_pkg.sv
package vita_tx_cfg_pkg;

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   localparam int GAIN_W         = 16;
   localparam int GAIN_FRAC_BITS = 14;  // Q2.14 gain.
   localparam int INTERP_W       = 8;

   typedef logic signed [GAIN_W-1:0] gain_t;
   typedef logic [INTERP_W-1:0]      interp_t;

   localparam set_addr_t SR_STREAMID = 8'd0;
   localparam set_addr_t SR_GAIN     = 8'd1;
   localparam set_addr_t SR_INTERP   = 8'd2;
   localparam set_addr_t SR_CLEAR    = 8'd3;

   localparam set_data_t STREAMID_RESET = 32'd0;
   localparam gain_t     GAIN_UNITY     = 16'sh4000;
   localparam interp_t   INTERP_RESET   = 8'd4;

endpackage

//--- common/vita_tx_pkt_pkg.sv
package vita_tx_pkt_pkg;

   typedef logic [35:0] stream_word_t;
   typedef logic [63:0] vita_time_t;
   typedef logic [31:0] iq_sample_t;
   typedef logic [3:0]  seqnum_t;
   typedef logic [99:0] sample_word_t;
   typedef logic [31:0] err_code_t;

   localparam int STREAM_SOP = 32;
   localparam int STREAM_EOP = 33;

   // Handoff word, sample in the low bits.
   localparam int SW_SAMPLE_LSB = 0;
   localparam int SW_TIME_LSB   = 32;
   localparam int SW_SOB        = 96;
   localparam int SW_EOB        = 97;
   localparam int SW_HAS_TIME   = 98;
   localparam int SW_SEQ_ERR    = 99;

   localparam int HDR_LEN_LSB  = 0;
   localparam int HDR_LEN_W    = 16;  // Words, header included.
   localparam int HDR_SEQ_LSB  = 16;
   localparam int HDR_SEQ_W    = 4;
   localparam int HDR_HAS_TIME = 20;
   localparam int HDR_EOB      = 24;
   localparam int HDR_TYPE_LSB = 28;

   localparam logic [3:0]  ERR_PKT_TYPE = 4'h4;
   localparam logic [15:0] ERR_PKT_LEN  = 16'd4;

   localparam err_code_t ERR_NONE     = 32'd0;
   localparam err_code_t ERR_UNDERRUN = 32'd1;
   localparam err_code_t ERR_LATE     = 32'd2;
   localparam err_code_t ERR_SEQ      = 32'd4;

endpackage

//--- logic/dsp_tx_scale.sv
`timescale 1ns/1ps

module dsp_tx_scale
   import vita_tx_pkt_pkg::*, vita_tx_cfg_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic        run_i,
   input  interp_t     interp_i,
   input  gain_t       gain_i,
   input  iq_sample_t  sample_i,
   output logic        strobe_o,
   output logic [15:0] dac_a_o,
   output logic [15:0] dac_b_o
);

   interp_t            period;
   interp_t            cnt;
   logic signed [31:0] prod_i;
   logic signed [31:0] prod_q;

   function automatic logic [15:0] scale_sat(input logic signed [31:0] prod);
      logic signed [31:0] shifted;
      shifted = prod >>> GAIN_FRAC_BITS;
      if (shifted > 32'sd32767)
         return 16'h7fff;
      else if (shifted < -32'sd32768)
         return 16'h8000;
      else
         return shifted[15:0];
   endfunction

   assign period = (interp_i == '0) ? interp_t'(1) : interp_i;  // Zero means every clock.
   assign prod_i = $signed(sample_i[31:16]) * gain_i;
   assign prod_q = $signed(sample_i[15:0]) * gain_i;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         cnt      <= '0;
         strobe_o <= 1'b0;
         dac_a_o  <= '0;
         dac_b_o  <= '0;
      end
      else if (!run_i)
      begin
         cnt      <= '0;
         strobe_o <= 1'b0;
         dac_a_o  <= '0;
         dac_b_o  <= '0;
      end
      else
      begin
         strobe_o <= (cnt == '0);
         cnt      <= (cnt >= period - 1'b1) ? '0 : cnt + 1'b1;
         if (strobe_o)
         begin
            dac_a_o <= scale_sat(prod_i);
            dac_b_o <= scale_sat(prod_q);
         end
      end
   end

endmodule

//--- logic/err_pkt_gen.sv
`timescale 1ns/1ps

module err_pkt_gen
   import vita_tx_pkt_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n_i,
   input  logic         clear_i,
   input  logic         trigger_i,
   input  err_code_t    error_code_i,
   input  seqnum_t      seqnum_i,
   input  logic [31:0]  streamid_i,
   input  vita_time_t   vita_time_i,
   output stream_word_t data_o,
   output logic         src_rdy_o,
   input  logic         dst_rdy_i
);

   typedef enum logic [2:0] {E_IDLE, E_HDR, E_SID, E_CODE, E_TIME} err_state_t;

   err_state_t  state;
   err_code_t   code_q;
   seqnum_t     seq_q;
   logic [31:0] sid_q;
   logic [31:0] time_q;

   assign src_rdy_o = (state != E_IDLE);

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         state <= E_IDLE;
      else if (clear_i)
         state <= E_IDLE;
      else
      begin
         case (state)
            E_IDLE: if (trigger_i) state <= E_HDR;  // Busy triggers are lost.
            E_HDR:  if (dst_rdy_i) state <= E_SID;
            E_SID:  if (dst_rdy_i) state <= E_CODE;
            E_CODE: if (dst_rdy_i) state <= E_TIME;
            E_TIME: if (dst_rdy_i) state <= E_IDLE;
            default: state <= E_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (trigger_i && (state == E_IDLE))
      begin
         code_q <= error_code_i;
         seq_q  <= seqnum_i;
         sid_q  <= streamid_i;
         time_q <= vita_time_i[31:0];
      end
   end

   always_comb
   begin
      data_o = '0;
      case (state)
         E_HDR:
         begin
            data_o[HDR_TYPE_LSB +: 4]         = ERR_PKT_TYPE;
            data_o[HDR_SEQ_LSB +: HDR_SEQ_W]  = seq_q;
            data_o[HDR_LEN_LSB +: HDR_LEN_W]  = ERR_PKT_LEN;
            data_o[STREAM_SOP]                = 1'b1;
         end
         E_SID:  data_o[31:0] = sid_q;
         E_CODE: data_o[31:0] = code_q;
         E_TIME:
         begin
            data_o[31:0]       = time_q;
            data_o[STREAM_EOP] = 1'b1;
         end
         default: data_o = '0;
      endcase
   end

endmodule

//--- logic/tx_settings.sv
`timescale 1ns/1ps

module tx_settings
   import vita_tx_cfg_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   output set_data_t streamid_o,
   output gain_t     gain_o,
   output interp_t   interp_o,
   output logic      clear_o,
   output logic      clear_seqnum_o
);

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         streamid_o     <= STREAMID_RESET;
         gain_o         <= GAIN_UNITY;
         interp_o       <= INTERP_RESET;
         clear_o        <= 1'b0;
         clear_seqnum_o <= 1'b0;
      end
      else
      begin
         clear_o        <= set_stb_i && (set_addr_i == SR_CLEAR);
         // Only a new id restarts the sequence check.
         clear_seqnum_o <= set_stb_i && (set_addr_i == SR_STREAMID) &&
                           (set_data_i != streamid_o);
         if (set_stb_i)
         begin
            case (set_addr_i)
               SR_STREAMID: streamid_o <= set_data_i;
               SR_GAIN:     gain_o     <= gain_t'(set_data_i[GAIN_W-1:0]);
               SR_INTERP:   interp_o   <= set_data_i[INTERP_W-1:0];
               default:     ;
            endcase
         end
      end
   end

   // Clear writes come spaced apart from the host.
   assert property (@(posedge clk) disable iff (!rst_n_i) clear_o |=> !clear_o);

endmodule

//--- tests/tb_vita_tx_chain.sv
`timescale 1ns/1ps

module tb_vita_tx_chain
   import vita_tx_pkt_pkg::*, vita_tx_cfg_pkg::*;
();

   localparam int          N_ROWS    = 6;
   localparam int          INTERP    = 4;
   localparam logic [31:0] STREAM_ID = 32'h0000_5a17;

   logic         clk;
   logic         rst_n_i;
   logic         set_stb_i;
   set_addr_t    set_addr_i;
   set_data_t    set_data_i;
   vita_time_t   vita_time_i;
   stream_word_t tx_data_i;
   logic         tx_src_rdy_i;
   logic         tx_dst_rdy_o;
   stream_word_t err_data_o;
   logic         err_src_rdy_o;
   logic         err_dst_rdy_i;
   logic [15:0]  dac_a_o;
   logic [15:0]  dac_b_o;
   logic         underrun_o;
   logic         run_o;

   string     r_name [N_ROWS];
   gain_t     r_gain [N_ROWS];
   seqnum_t   r_seq_off [N_ROWS];
   logic      r_timed [N_ROWS];
   int        r_time_off [N_ROWS];
   int        r_count [N_ROWS];
   logic      r_eob [N_ROWS];
   logic      r_stall [N_ROWS];
   err_code_t r_err [N_ROWS];

   integer  seed = 32'h7449_f35c;
   int      cycles = 0;
   int      limit = 0;
   seqnum_t next_seq = '0;

   vita_tx_chain dut_i (
      .clk(clk), .rst_n_i(rst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .vita_time_i(vita_time_i),
      .tx_data_i(tx_data_i), .tx_src_rdy_i(tx_src_rdy_i), .tx_dst_rdy_o(tx_dst_rdy_o),
      .err_data_o(err_data_o), .err_src_rdy_o(err_src_rdy_o), .err_dst_rdy_i(err_dst_rdy_i),
      .dac_a_o(dac_a_o), .dac_b_o(dac_b_o), .underrun_o(underrun_o), .run_o(run_o));

   tx_checker chk_i (
      .clk(clk), .rst_n_i(rst_n_i), .run_i(run_o), .underrun_i(underrun_o),
      .strobe_i(dut_i.strobe), .sample_valid_i(dut_i.sample_src_rdy),
      .dac_a_i(dac_a_o), .dac_b_i(dac_b_o), .err_data_i(err_data_o),
      .err_src_rdy_i(err_src_rdy_o), .err_dst_rdy_i(err_dst_rdy_i),
      .vita_time_i(vita_time_i));

   always #4 clk = ~clk;

   // Time base and random back-pressure on the error stream.
   always @(posedge clk)
   begin
      #1;
      vita_time_i   = vita_time_i + 64'd1;
      err_dst_rdy_i = (($random(seed) & 3) != 0);
   end

   task set_row(input int r, input string name, input gain_t g, input seqnum_t so,
                input logic timed, input int toff, input int cnt, input logic eob,
                input logic stall, input err_code_t err);
      r_name[r]     = name;
      r_gain[r]     = g;
      r_seq_off[r]  = so;
      r_timed[r]    = timed;
      r_time_off[r] = toff;
      r_count[r]    = cnt;
      r_eob[r]      = eob;
      r_stall[r]    = stall;
      r_err[r]      = err;
   endtask

   task write_setting(input set_addr_t addr, input set_data_t data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(posedge clk);
      #1;
      set_stb_i = 1'b0;
   endtask

   task push_word(input stream_word_t w);
      logic taken;
      tx_data_i    = w;
      tx_src_rdy_i = 1'b1;
      taken        = 1'b0;
      while (!taken)
      begin
         @(negedge clk);
         taken = tx_dst_rdy_o;
         @(posedge clk);
         #1;
      end
      tx_src_rdy_i = 1'b0;
   endtask

   task automatic run_row(input int r);
      iq_sample_t   payload [16];
      logic [31:0]  rnd;
      stream_word_t w;
      seqnum_t      seq;
      vita_time_t   t;
      int           played;
      int           i;
      seq      = next_seq + r_seq_off[r];
      next_seq = seq + 4'd1;
      played   = (r_err[r] == ERR_LATE) ? 0 : (r_stall[r] ? r_count[r] / 2 : r_count[r]);
      write_setting(SR_STREAMID, STREAM_ID);
      write_setting(SR_GAIN, {16'h0, r_gain[r]});
      write_setting(SR_INTERP, set_data_t'(INTERP));
      t = vita_time_i + vita_time_t'(longint'(r_time_off[r]));
      if (r_timed[r] && r_time_off[r] < 0)
         while (vita_time_i <= t)
         begin
            @(posedge clk);
            #1;
         end
      for (i = 0; i < r_count[r]; i++)
      begin
         rnd = $random(seed);
         if (i % 2 == 0)
            payload[i] = {rnd[31], ~rnd[31], rnd[29:16], rnd[15], ~rnd[15], rnd[13:0]};
         else
            payload[i] = {{5{rnd[31]}}, rnd[30:20], {5{rnd[15]}}, rnd[14:4]};  // Small.
      end
      chk_i.start_row(r_name[r], r_gain[r], seq, STREAM_ID, r_timed[r], t, r_err[r]);
      for (i = 0; i < played; i++)
         chk_i.add_sample(payload[i]);
      w = '0;
      w[HDR_LEN_LSB +: HDR_LEN_W] = 16'(1 + (r_timed[r] ? 2 : 0) + r_count[r]);
      w[HDR_SEQ_LSB +: HDR_SEQ_W] = seq;
      w[HDR_HAS_TIME]             = r_timed[r];
      w[HDR_EOB]                  = r_eob[r];
      w[STREAM_SOP]               = 1'b1;
      push_word(w);
      if (r_timed[r])
      begin
         push_word({4'h0, t[63:32]});
         push_word({4'h0, t[31:0]});
      end
      for (i = 0; i < r_count[r]; i++)
      begin
         if (r_stall[r] && i == r_count[r] / 2)
         begin
            // Source goes quiet until underrun.
            do @(negedge clk); while (!underrun_o);
            @(posedge clk);
            #1;
         end
         w             = {4'h0, payload[i]};
         w[STREAM_EOP] = (i == r_count[r] - 1);
         push_word(w);
      end
      do @(negedge clk); while (!chk_i.row_done());
      repeat (8) @(negedge clk);
      if (r_stall[r])
      begin
         chk_i.check_underrun(1'b1, "before clear");
         @(posedge clk);
         #1;
         write_setting(SR_CLEAR, 32'd1);
         repeat (2) @(negedge clk);
         chk_i.check_underrun(1'b0, "after clear");
      end
      chk_i.end_row();
      @(posedge clk);
      #1;
   endtask

   initial
   begin
      @(posedge rst_n_i);
      while (cycles < limit)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Run timed out after %0d cycles", cycles);
      $display("TESTS FAILED");
      $finish;
   end

   initial
   begin
      int r;
      clk           = 1'b0;
      rst_n_i       = 1'b0;
      set_stb_i     = 1'b0;
      set_addr_i    = '0;
      set_data_i    = '0;
      vita_time_i   = '0;
      tx_data_i     = '0;
      tx_src_rdy_i  = 1'b0;
      err_dst_rdy_i = 1'b1;
      set_row(0, "untimed_unity", GAIN_UNITY, 4'd0, 1'b0, 0, 8, 1'b1, 1'b0, ERR_NONE);
      set_row(1, "timed_burst", GAIN_UNITY, 4'd0, 1'b1, 30, 6, 1'b1, 1'b0, ERR_NONE);
      set_row(2, "late_packet", GAIN_UNITY, 4'd0, 1'b1, -10, 4, 1'b1, 1'b0, ERR_LATE);
      set_row(3, "seq_gap", GAIN_UNITY, 4'd3, 1'b0, 0, 6, 1'b1, 1'b0, ERR_SEQ);
      set_row(4, "underrun", GAIN_UNITY, 4'd0, 1'b0, 0, 8, 1'b0, 1'b1, ERR_UNDERRUN);
      set_row(5, "gain_saturation", 16'sh7fff, 4'd0, 1'b0, 0, 8, 1'b1, 1'b0, ERR_NONE);
      for (r = 0; r < N_ROWS; r++)
         limit += r_count[r] * INTERP + 50;
      repeat (5) @(posedge clk);
      #1;
      rst_n_i = 1'b1;
      for (r = 0; r < N_ROWS; r++)
         run_row(r);
      chk_i.print_counts();
      if (chk_i.errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

//--- tests/tx_checker.sv
`timescale 1ns/1ps

module tx_checker
   import vita_tx_pkt_pkg::*, vita_tx_cfg_pkg::*;
(
   input logic         clk,
   input logic         rst_n_i,
   input logic         run_i,
   input logic         underrun_i,
   input logic         strobe_i,
   input logic         sample_valid_i,
   input logic [15:0]  dac_a_i,
   input logic [15:0]  dac_b_i,
   input stream_word_t err_data_i,
   input logic         err_src_rdy_i,
   input logic         err_dst_rdy_i,
   input vita_time_t   vita_time_i
);

   iq_sample_t   exp_q [$];
   string        row_name;
   gain_t        row_gain;
   seqnum_t      row_seq;
   logic [31:0]  row_sid;
   logic         row_timed;
   vita_time_t   row_time;
   vita_time_t   row_start;
   err_code_t    row_err;
   int           played = 0;
   int           err_pkts = 0;
   int           row_errors = 0;
   int           errors = 0;
   int           rows_ok = 0;
   int           rows_bad = 0;
   int           wpos = 0;
   logic         pending = 1'b0;
   logic         run_d = 1'b0;
   stream_word_t ew [4];

   // Q2.14 gain with a floored shift and a 16-bit clip.
   function automatic logic [15:0] expect_dac(input logic [15:0] x, input gain_t g);
      int a;
      int p;
      a = $signed(x);
      p = a * g;
      p = p >>> 14;
      if (p > 32767)
         return 16'h7fff;
      if (p < -32768)
         return 16'h8000;
      return p[15:0];
   endfunction

   task report_error(input string msg);
      $display("FAILED %0t: %s", $time, msg);
      errors++;
      row_errors++;
   endtask

   task start_row(input string name, input gain_t g, input seqnum_t seq,
                  input logic [31:0] sid, input logic timed, input vita_time_t t,
                  input err_code_t code);
      row_name   = name;
      row_gain   = g;
      row_seq    = seq;
      row_sid    = sid;
      row_timed  = timed;
      row_time   = t;
      row_start  = vita_time_i;
      row_err    = code;
      played     = 0;
      err_pkts   = 0;
      row_errors = 0;
      exp_q.delete();
   endtask

   task add_sample(input iq_sample_t s);
      exp_q.push_back(s);
   endtask

   function automatic logic row_done();
      return (exp_q.size() == 0) && !run_i &&
             (err_pkts >= ((row_err != ERR_NONE) ? 1 : 0));
   endfunction

   task check_underrun(input logic expected, input string when);
      if (underrun_i !== expected)
         report_error($sformatf("underrun_o is %b %s, expected %b", underrun_i, when, expected));
   endtask

   task check_dac();
      iq_sample_t  s;
      logic [15:0] ea;
      logic [15:0] eb;
      if (exp_q.size() == 0)
         report_error("DAC update with no sample pending");
      else
      begin
         s  = exp_q.pop_front();
         ea = expect_dac(s[31:16], row_gain);
         eb = expect_dac(s[15:0], row_gain);
         if (dac_a_i !== ea || dac_b_i !== eb)
            report_error($sformatf("sample %0d DAC %h/%h, expected %h/%h",
                                   played, dac_a_i, dac_b_i, ea, eb));
         if (row_timed && played == 0 && vita_time_i < row_time)
            report_error($sformatf("first sample at time %0d, before %0d",
                                   vita_time_i, row_time));
         played++;
      end
   endtask

   task check_err_pkt();
      err_pkts++;
      if (row_err == ERR_NONE)
         report_error("error packet with no error expected");
      else if (wpos != 4 || !ew[0][STREAM_SOP] || !ew[3][STREAM_EOP])
         report_error($sformatf("error packet framing wrong, %0d words", wpos));
      else
      begin
         if (ew[0][31:28] != ERR_PKT_TYPE || ew[0][19:16] != row_seq || ew[0][15:0] != 16'd4)
            report_error($sformatf("error header %h, seqnum %0d expected", ew[0][31:0], row_seq));
         if (ew[1][31:0] != row_sid)
            report_error($sformatf("error stream id %h, expected %h", ew[1][31:0], row_sid));
         if (ew[2][31:0] != row_err)
            report_error($sformatf("error code %h, expected %h", ew[2][31:0], row_err));
         if (ew[3][31:0] < row_start[31:0] || ew[3][31:0] > vita_time_i[31:0])
            report_error($sformatf("error time %0d outside %0d to %0d", ew[3][31:0],
                                   row_start[31:0], vita_time_i[31:0]));
      end
   endtask

   // Inputs settle after the rising edge.
   always @(negedge clk)
   begin
      if (rst_n_i)
      begin
         if (pending)
            check_dac();
         else if (!run_i && !run_d && (dac_a_i != 16'h0 || dac_b_i != 16'h0))
            report_error("DAC not zero while run is low");
         pending = strobe_i && sample_valid_i && run_i;  // DAC loads on the next edge.
         run_d   = run_i;
         if (err_src_rdy_i && err_dst_rdy_i)
         begin
            ew[wpos] = err_data_i;
            wpos++;
            if (err_data_i[STREAM_EOP] || wpos == 4)
            begin
               check_err_pkt();
               wpos = 0;
            end
         end
      end
   end

   task end_row();
      if (exp_q.size() != 0)
         report_error($sformatf("%0d samples never reached the DAC", exp_q.size()));
      if (err_pkts != ((row_err != ERR_NONE) ? 1 : 0))
         report_error($sformatf("%0d error packets seen", err_pkts));
      if (row_errors == 0)
         rows_ok++;
      else
         rows_bad++;
      $display("test %s: %s, %0d samples played, %0d error packets",
               row_name, (row_errors == 0) ? "ok" : "bad", played, err_pkts);
   endtask

   task print_counts();
      $display("%0d tests ok, %0d tests bad, %0d errors", rows_ok, rows_bad, errors);
   endtask

endmodule

//--- vita_tx/vita_tx_chain.sv
`timescale 1ns/1ps

module vita_tx_chain
   import vita_tx_pkt_pkg::*, vita_tx_cfg_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n_i,
   input  logic         set_stb_i,
   input  set_addr_t    set_addr_i,
   input  set_data_t    set_data_i,
   input  vita_time_t   vita_time_i,
   input  stream_word_t tx_data_i,
   input  logic         tx_src_rdy_i,
   output logic         tx_dst_rdy_o,
   output stream_word_t err_data_o,
   output logic         err_src_rdy_o,
   input  logic         err_dst_rdy_i,
   output logic [15:0]  dac_a_o,
   output logic [15:0]  dac_b_o,
   output logic         underrun_o,
   output logic         run_o
);

   set_data_t    streamid;
   gain_t        gain;
   interp_t      interp;
   logic         clear_vita;
   logic         clear_seqnum;
   sample_word_t sample_data;
   logic         sample_src_rdy;
   logic         sample_dst_rdy;
   seqnum_t      current_seqnum;
   iq_sample_t   sample_tx;
   logic         strobe;
   logic         error_pulse;
   err_code_t    error_code;

   tx_settings tx_settings_i (
      .clk(clk), .rst_n_i(rst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .streamid_o(streamid), .gain_o(gain), .interp_o(interp),
      .clear_o(clear_vita), .clear_seqnum_o(clear_seqnum));

   vita_tx_deframer vita_tx_deframer_i (
      .clk(clk), .rst_n_i(rst_n_i), .clear_i(clear_vita), .clear_seqnum_i(clear_seqnum),
      .data_i(tx_data_i), .src_rdy_i(tx_src_rdy_i), .dst_rdy_o(tx_dst_rdy_o),
      .sample_o(sample_data), .sample_src_rdy_o(sample_src_rdy),
      .sample_dst_rdy_i(sample_dst_rdy), .current_seqnum_o(current_seqnum));

   // Underrun is the control stage's sticky error.
   vita_tx_control vita_tx_control_i (
      .clk(clk), .rst_n_i(rst_n_i), .clear_i(clear_vita), .vita_time_i(vita_time_i),
      .sample_i(sample_data), .sample_src_rdy_i(sample_src_rdy),
      .sample_dst_rdy_o(sample_dst_rdy), .strobe_i(strobe), .sample_o(sample_tx),
      .run_o(run_o), .error_o(underrun_o), .error_pulse_o(error_pulse),
      .error_code_o(error_code));

   dsp_tx_scale dsp_tx_scale_i (
      .clk(clk), .rst_n_i(rst_n_i), .run_i(run_o), .interp_i(interp), .gain_i(gain),
      .sample_i(sample_tx), .strobe_o(strobe), .dac_a_o(dac_a_o), .dac_b_o(dac_b_o));

   err_pkt_gen err_pkt_gen_i (
      .clk(clk), .rst_n_i(rst_n_i), .clear_i(clear_vita), .trigger_i(error_pulse),
      .error_code_i(error_code), .seqnum_i(current_seqnum), .streamid_i(streamid),
      .vita_time_i(vita_time_i), .data_o(err_data_o), .src_rdy_o(err_src_rdy_o),
      .dst_rdy_i(err_dst_rdy_i));

endmodule

//--- vita_tx/vita_tx_control.sv
`timescale 1ns/1ps

module vita_tx_control
   import vita_tx_pkt_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n_i,
   input  logic         clear_i,
   input  vita_time_t   vita_time_i,
   input  sample_word_t sample_i,
   input  logic         sample_src_rdy_i,
   output logic         sample_dst_rdy_o,
   input  logic         strobe_i,
   output iq_sample_t   sample_o,
   output logic         run_o,
   output logic         error_o,
   output logic         error_pulse_o,
   output err_code_t    error_code_o
);

   typedef enum logic [2:0] {IDLE, WAIT_TIME, RUN, DROP, ERROR} ctrl_state_t;

   ctrl_state_t state;
   ctrl_state_t state_nxt;
   vita_time_t  sample_time;
   logic        timed_start;
   logic        time_reached;
   logic        is_eob;
   logic        is_sob;
   logic        pulse_nxt;
   err_code_t   code_nxt;

   assign sample_o     = sample_i[SW_SAMPLE_LSB +: 32];
   assign sample_time  = sample_i[SW_TIME_LSB +: 64];
   assign is_sob       = sample_i[SW_SOB];
   assign is_eob       = sample_i[SW_EOB];
   assign timed_start  = sample_i[SW_HAS_TIME] && is_sob;
   assign time_reached = (vita_time_i >= sample_time);

   assign run_o   = (state == RUN) || ((state == WAIT_TIME) && time_reached);
   assign error_o = (state == ERROR);

   always_comb
   begin
      state_nxt        = state;
      pulse_nxt        = 1'b0;
      code_nxt         = ERR_NONE;
      sample_dst_rdy_o = 1'b0;
      case (state)
         IDLE:
            if (sample_src_rdy_i)
            begin
               if (timed_start && time_reached)
               begin
                  // A late first sample is dropped at once.
                  sample_dst_rdy_o = 1'b1;
                  pulse_nxt        = 1'b1;
                  code_nxt         = ERR_LATE;
                  state_nxt        = is_eob ? IDLE : DROP;
               end
               else if (timed_start)
                  state_nxt = WAIT_TIME;
               else
                  state_nxt = RUN;
            end
         WAIT_TIME:
            if (time_reached)
               state_nxt = RUN;
         RUN:
         begin
            sample_dst_rdy_o = strobe_i;
            if (strobe_i && !sample_src_rdy_i)
            begin
               pulse_nxt = 1'b1;
               code_nxt  = ERR_UNDERRUN;
               state_nxt = ERROR;
            end
            else if (strobe_i)
            begin
               if (sample_i[SW_SEQ_ERR])
               begin
                  pulse_nxt = 1'b1;
                  code_nxt  = ERR_SEQ;
               end
               if (is_eob)
                  state_nxt = IDLE;
            end
         end
         DROP:
            if (sample_src_rdy_i && is_sob)
               state_nxt = IDLE;  // Next burst is kept.
            else
            begin
               sample_dst_rdy_o = 1'b1;
               if (sample_src_rdy_i && is_eob)
                  state_nxt = IDLE;
            end
         ERROR:
            sample_dst_rdy_o = 1'b1;  // Drain until cleared.
         default:
            state_nxt = IDLE;
      endcase
      if (clear_i)
         state_nxt = IDLE;
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state         <= IDLE;
         error_pulse_o <= 1'b0;
         error_code_o  <= ERR_NONE;
      end
      else
      begin
         state         <= state_nxt;
         error_pulse_o <= pulse_nxt;
         if (pulse_nxt)
            error_code_o <= code_nxt;
      end
   end

   // The waiting sample stays in the handoff register.
   assert property (@(posedge clk) disable iff (!rst_n_i || clear_i)
      (state == WAIT_TIME) |=> sample_src_rdy_i && $stable(sample_i));

endmodule

//--- vita_tx/vita_tx_deframer.sv
`timescale 1ns/1ps

module vita_tx_deframer
   import vita_tx_pkt_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n_i,
   input  logic         clear_i,
   input  logic         clear_seqnum_i,
   input  stream_word_t data_i,
   input  logic         src_rdy_i,
   output logic         dst_rdy_o,
   output sample_word_t sample_o,
   output logic         sample_src_rdy_o,
   input  logic         sample_dst_rdy_i,
   output seqnum_t      current_seqnum_o
);

   typedef enum logic [1:0] {HEADER, TIME_HI, TIME_LO, SAMPLES} dfr_state_t;

   dfr_state_t  state;
   logic [15:0] words_left;
   logic [15:0] hdr_len;
   seqnum_t     hdr_seq;
   seqnum_t     expected_seq;
   logic        hdr_timed;
   logic        hdr_eob;
   logic        first_q;
   logic        seq_err_q;
   logic [31:0] time_hi;
   vita_time_t  pkt_time;
   logic        accept;
   logic        last_word;

   assign dst_rdy_o = !sample_src_rdy_o || sample_dst_rdy_i;
   assign accept    = src_rdy_i && dst_rdy_o;
   assign hdr_len   = data_i[HDR_LEN_LSB +: HDR_LEN_W];
   assign hdr_seq   = data_i[HDR_SEQ_LSB +: HDR_SEQ_W];

   // A short packet ends on its EOP word.
   assign last_word = data_i[STREAM_EOP] ||
                      ((state == HEADER) ? (hdr_len <= 16'd1) : (words_left <= 16'd1));

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state            <= HEADER;
         words_left       <= '0;
         hdr_timed        <= 1'b0;
         hdr_eob          <= 1'b0;
         first_q          <= 1'b0;
         seq_err_q        <= 1'b0;
         sample_src_rdy_o <= 1'b0;
         expected_seq     <= '0;
         current_seqnum_o <= '0;
      end
      else
      begin
         if (sample_dst_rdy_i)
            sample_src_rdy_o <= 1'b0;
         if (clear_i)
         begin
            state            <= HEADER;
            sample_src_rdy_o <= 1'b0;
         end
         else if (accept)
         begin
            words_left <= ((state == HEADER) ? hdr_len : words_left) - 1'b1;
            case (state)
               HEADER:
               begin
                  hdr_timed        <= data_i[HDR_HAS_TIME];
                  hdr_eob          <= data_i[HDR_EOB];
                  first_q          <= 1'b1;
                  seq_err_q        <= (hdr_seq != expected_seq);
                  expected_seq     <= hdr_seq + 1'b1;  // Resync on a gap.
                  current_seqnum_o <= hdr_seq;
                  if (last_word)
                     state <= HEADER;
                  else if (data_i[HDR_HAS_TIME])
                     state <= TIME_HI;
                  else
                     state <= SAMPLES;
               end
               TIME_HI: state <= last_word ? HEADER : TIME_LO;
               TIME_LO: state <= last_word ? HEADER : SAMPLES;
               SAMPLES:
               begin
                  sample_src_rdy_o <= 1'b1;
                  first_q          <= 1'b0;
                  if (last_word)
                     state <= HEADER;
               end
            endcase
         end
         if (clear_seqnum_i)
            expected_seq <= '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         case (state)
            HEADER:  pkt_time <= '0;
            TIME_HI: time_hi  <= data_i[31:0];
            TIME_LO: pkt_time <= {time_hi, data_i[31:0]};
            SAMPLES:
            begin
               sample_o[SW_SAMPLE_LSB +: 32] <= data_i[31:0];
               sample_o[SW_TIME_LSB +: 64]   <= pkt_time;
               sample_o[SW_SOB]              <= first_q && hdr_timed;
               sample_o[SW_EOB]              <= last_word && hdr_eob;
               sample_o[SW_HAS_TIME]         <= hdr_timed;
               sample_o[SW_SEQ_ERR]          <= first_q && seq_err_q;
            end
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n_i || clear_i)
      sample_src_rdy_o && !sample_dst_rdy_i |=> sample_src_rdy_o && $stable(sample_o));

endmodule
